/* id_pkg.sv */
// --------------------------------------------------------------------------
// Decode stage package
// Instruction and field types, major opcodes, register numbers and the
// state encoding of the cm.push sequencer
// --------------------------------------------------------------------------
package id_pkg;

  // ------------------------------------------------------------------------
  // Instruction and field types
  // ------------------------------------------------------------------------
  // Full 32-bit instruction word
  typedef logic [31:0] instr_t;
  // Compressed 16-bit instruction
  typedef logic [15:0] cinstr_t;
  // Architectural register number
  typedef logic [4:0] reg_idx_t;
  // Register-list field of cm.push
  typedef logic [3:0] rlist_t;
  // Micro-op index within a macro, 0 to 11
  typedef logic [3:0] step_t;

  // ------------------------------------------------------------------------
  // Major opcodes
  // ------------------------------------------------------------------------
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // ------------------------------------------------------------------------
  // Register numbers used by the push expansion
  // ------------------------------------------------------------------------
  localparam reg_idx_t REG_RA = 5'd1;
  localparam reg_idx_t REG_SP = 5'd2;
  localparam reg_idx_t REG_S0 = 5'd8;
  localparam reg_idx_t REG_S1 = 5'd9;

  // Push sequencer states
  typedef enum logic [1:0] {
    IDLE,
    STORE,
    ADJUST
  } push_state_e;

endpackage

/* rvc_expander.sv */
// --------------------------------------------------------------------------
// Compressed instruction expander
// Expands C.NOP/C.ADDI, C.LI, C.MV, C.ADD and C.JR to 32-bit encodings,
// detects cm.push and flags every other compressed encoding as illegal
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module rvc_expander
  import id_pkg::*;
(
  input  instr_t       instr_i,
  output instr_t       instr_o,
  output logic         compressed_o,
  output logic         illegal_o,
  output logic         push_o,
  output rlist_t       rlist_o,
  output logic [1:0]   spimm_o
);

  cinstr_t     c;
  reg_idx_t    rd;
  reg_idx_t    rs2;
  logic [11:0] imm12;
  logic        push_enc;
  logic        rlist_ok;

  assign c     = instr_i[15:0];
  assign rd    = c[11:7];
  assign rs2   = c[6:2];
  // Sign-extended CI immediate
  assign imm12 = {{7{c[12]}}, c[6:2]};

  // cm.push fields, only meaningful when push_enc is set
  assign rlist_o  = c[7:4];
  assign spimm_o  = c[3:2];
  assign push_enc = (c[15:8] == 8'b1011_1000) && (c[1:0] == 2'b10);
  // rlist 0..3 are reserved, 15 is outside the supported register range
  assign rlist_ok = (rlist_o >= 4'd4) && (rlist_o != 4'd15);

  always_comb begin
    instr_o      = instr_i;
    compressed_o = 1'b0;
    illegal_o    = 1'b0;
    push_o       = 1'b0;

    if (c[1:0] != 2'b11) begin
      compressed_o = 1'b1;
      // Default for anything outside the subset
      instr_o      = {16'h0000, c};
      illegal_o    = 1'b1;

      unique case (c[1:0])
        2'b01: begin
          unique case (c[15:13])
            // C.ADDI, C.NOP when rd is x0
            3'b000: begin
              instr_o   = {imm12, rd, 3'b000, rd, OPC_OP_IMM};
              illegal_o = 1'b0;
            end
            // C.LI
            3'b010: begin
              instr_o   = {imm12, 5'd0, 3'b000, rd, OPC_OP_IMM};
              illegal_o = 1'b0;
            end
            default: ;
          endcase
        end

        2'b10: begin
          if (c[15:13] == 3'b100) begin
            if (!c[12]) begin
              if (rs2 != 5'd0) begin
                // C.MV
                instr_o   = {7'b0, rs2, 5'd0, 3'b000, rd, OPC_OP};
                illegal_o = 1'b0;
              end else if (rd != 5'd0) begin
                // C.JR
                instr_o   = {12'h000, rd, 3'b000, 5'd0, OPC_JALR};
                illegal_o = 1'b0;
              end
            end else if (rs2 != 5'd0) begin
              // C.ADD
              instr_o   = {7'b0, rs2, rd, 3'b000, rd, OPC_OP};
              illegal_o = 1'b0;
            end
          end else if (push_enc && rlist_ok) begin
            // The word itself is replaced by micro-ops downstream
            illegal_o = 1'b0;
            push_o    = 1'b1;
          end
        end

        default: ;
      endcase
    end
  end

endmodule

/* push_sequencer.sv */
// --------------------------------------------------------------------------
// cm.push sequencer
// Steps through the store micro-ops and the final stack adjust, and holds
// fetch until the adjust is written to the issue register
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module push_sequencer
  import id_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flush_i,
  input  logic push_i,
  input  logic load_i,
  input  logic last_store_i,
  output logic step_en_o,
  output logic step_clr_o,
  output logic uop_sel_o,
  output logic active_o,
  output logic stall_o
);

  push_state_e state_q, state_d;

  always_comb begin
    state_d    = state_q;
    step_en_o  = 1'b0;
    step_clr_o = 1'b0;
    uop_sel_o  = 1'b0;
    active_o   = 1'b0;
    stall_o    = 1'b0;

    unique case (state_q)
      IDLE: begin
        // First store goes out in the same cycle the macro is seen
        if (push_i) begin
          active_o = 1'b1;
          stall_o  = 1'b1;
          if (load_i) begin
            if (last_store_i) begin
              state_d = ADJUST;
            end else begin
              step_en_o = 1'b1;
              state_d   = STORE;
            end
          end
        end
      end

      STORE: begin
        active_o = 1'b1;
        stall_o  = 1'b1;
        if (load_i) begin
          if (last_store_i) begin
            state_d = ADJUST;
          end else begin
            step_en_o = 1'b1;
          end
        end
      end

      ADJUST: begin
        // Fetch is released on the cycle the adjust loads
        active_o  = 1'b1;
        uop_sel_o = 1'b1;
        if (load_i) begin
          step_clr_o = 1'b1;
          state_d    = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase

    if (flush_i) begin
      state_d    = IDLE;
      step_clr_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* push_step_counter.sv */
// --------------------------------------------------------------------------
// Push step counter
// Counts accepted store micro-ops and flags the last one of the macro
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module push_step_counter
  import id_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  en_i,
  input  logic  clr_i,
  input  step_t count_i,
  output step_t step_o,
  output logic  last_o
);

  step_t step_q;

  // Clear wins over a step
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q <= '0;
    end else if (clr_i) begin
      step_q <= '0;
    end else if (en_i) begin
      step_q <= step_q + 4'd1;
    end
  end

  assign step_o = step_q;
  assign last_o = (step_q == count_i - 4'd1);

endmodule

/* push_uop_gen.sv */
// --------------------------------------------------------------------------
// Push micro-op generator
// Builds the sw micro-op for the current step, or the addi that moves the
// stack pointer once all registers are stored
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module push_uop_gen
  import id_pkg::*;
(
  input  step_t      step_i,
  input  rlist_t     rlist_i,
  input  logic [1:0] spimm_i,
  input  logic       adjust_i,
  output instr_t     uop_o,
  output step_t      count_o
);

  reg_idx_t    src_reg;
  logic [11:0] st_off;
  logic [11:0] base_sz;
  logic [11:0] stack_sz;
  logic [11:0] adj_imm;

  // rlist 4 stores ra only, each further value adds one s register
  assign count_o = rlist_i - 4'd3;

  // Register order is ra, s0, s1, then s2 upwards from x18
  always_comb begin
    unique case (step_i)
      4'd0:    src_reg = REG_RA;
      4'd1:    src_reg = REG_S0;
      4'd2:    src_reg = REG_S1;
      default: src_reg = reg_idx_t'({1'b0, step_i} + 5'd15);
    endcase
  end

  // Store offset is -4 * (step + 1) from sp
  assign st_off = 12'd0 - {5'd0, ({1'b0, step_i} + 5'd1), 2'b00};

  // ------------------------------------------------------------------------
  // Stack adjust, register area rounded to 16 bytes plus 16 * spimm
  // ------------------------------------------------------------------------
  assign base_sz  = ({6'd0, count_o, 2'b00} + 12'd15) & 12'hff0;
  assign stack_sz = base_sz + {6'd0, spimm_i, 4'b0000};
  assign adj_imm  = 12'd0 - stack_sz;

  always_comb begin
    if (adjust_i) begin
      uop_o = {adj_imm, REG_SP, 3'b000, REG_SP, OPC_OP_IMM};
    end else begin
      uop_o = {st_off[11:5], src_reg, REG_SP, 3'b010, st_off[4:0], OPC_STORE};
    end
  end

endmodule

/* issue_reg.sv */
// --------------------------------------------------------------------------
// ID/issue pipeline register
// Holds one decoded entry until the issue side acknowledges it
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module issue_reg
  import id_pkg::*;
#(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 fetch_valid_i,
  input  logic                 stall_i,
  input  instr_t               instr_i,
  input  logic [AddrWidth-1:0] pc_i,
  input  logic                 compressed_i,
  input  logic                 illegal_i,
  input  logic                 ack_i,
  output logic                 load_o,
  output logic                 fetch_ready_o,
  output logic                 valid_o,
  output instr_t               instr_o,
  output logic [AddrWidth-1:0] pc_o,
  output logic                 compressed_o,
  output logic                 illegal_o,
  output logic                 ctrl_flow_o
);

  logic valid_q;
  logic ctrl_flow;

  // Slot is free when empty or retiring this cycle
  assign load_o        = (!valid_q || ack_i) && fetch_valid_i && !flush_i;
  assign fetch_ready_o = load_o && !stall_i;

  assign ctrl_flow = instr_i[6:0] inside {OPC_JAL, OPC_JALR, OPC_BRANCH};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (load_o) begin
      valid_q <= 1'b1;
    end else if (ack_i) begin
      valid_q <= 1'b0;
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (load_o) begin
      instr_o      <= instr_i;
      pc_o         <= pc_i;
      compressed_o <= compressed_i;
      illegal_o    <= illegal_i;
      ctrl_flow_o  <= ctrl_flow;
    end
  end

  assign valid_o = valid_q;

endmodule

/* id_stage_top.sv */
// --------------------------------------------------------------------------
// Instruction decode stage
// Compressed expansion, cm.push micro-op sequencing and the ID/issue
// pipeline register
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module id_stage_top
  import id_pkg::*;
#(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Fetch side
  input  logic                 fetch_valid_i,
  input  instr_t               fetch_instr_i,
  input  logic [AddrWidth-1:0] fetch_pc_i,
  output logic                 fetch_ready_o,
  // Issue side
  output logic                 issue_valid_o,
  output instr_t               issue_instr_o,
  output logic [AddrWidth-1:0] issue_pc_o,
  output logic                 issue_compressed_o,
  output logic                 issue_illegal_o,
  output logic                 issue_ctrl_flow_o,
  input  logic                 issue_ack_i
);

  instr_t     exp_instr;
  logic       exp_compressed;
  logic       exp_illegal;
  logic       push;
  rlist_t     rlist;
  logic [1:0] spimm;

  logic       step_en;
  logic       step_clr;
  logic       uop_sel;
  logic       active;
  logic       stall;
  logic       load;
  logic       last_store;
  step_t      step;
  step_t      count;
  instr_t     uop;

  instr_t     sel_instr;
  logic       sel_compressed;
  logic       sel_illegal;

  rvc_expander i_rvc_expander (
    .instr_i      (fetch_instr_i),
    .instr_o      (exp_instr),
    .compressed_o (exp_compressed),
    .illegal_o    (exp_illegal),
    .push_o       (push),
    .rlist_o      (rlist),
    .spimm_o      (spimm)
  );

  push_sequencer i_push_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .push_i       (push),
    .load_i       (load),
    .last_store_i (last_store),
    .step_en_o    (step_en),
    .step_clr_o   (step_clr),
    .uop_sel_o    (uop_sel),
    .active_o     (active),
    .stall_o      (stall)
  );

  push_step_counter i_push_step_counter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .en_i    (step_en),
    .clr_i   (step_clr),
    .count_i (count),
    .step_o  (step),
    .last_o  (last_store)
  );

  push_uop_gen i_push_uop_gen (
    .step_i   (step),
    .rlist_i  (rlist),
    .spimm_i  (spimm),
    .adjust_i (uop_sel),
    .uop_o    (uop),
    .count_o  (count)
  );

  // Micro-ops replace the expanded word while a macro runs
  assign sel_instr      = active ? uop : exp_instr;
  assign sel_compressed = active ? 1'b1 : exp_compressed;
  assign sel_illegal    = active ? 1'b0 : exp_illegal;

  issue_reg #(
    .AddrWidth (AddrWidth)
  ) i_issue_reg (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .stall_i       (stall),
    .instr_i       (sel_instr),
    .pc_i          (fetch_pc_i),
    .compressed_i  (sel_compressed),
    .illegal_i     (sel_illegal),
    .ack_i         (issue_ack_i),
    .load_o        (load),
    .fetch_ready_o (fetch_ready_o),
    .valid_o       (issue_valid_o),
    .instr_o       (issue_instr_o),
    .pc_o          (issue_pc_o),
    .compressed_o  (issue_compressed_o),
    .illegal_o     (issue_illegal_o),
    .ctrl_flow_o   (issue_ctrl_flow_o)
  );

endmodule

/* tb_id_stage.sv */
// --------------------------------------------------------------------------
// Decode stage testbench
// Drives fetch entries and random ack gaps, models the expansion rules and
// compares each acknowledged issue entry with the expected one
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_id_stage;

  logic        clk_i, rst_ni, flush_i, fetch_valid_i, fetch_ready_o, issue_ack_i;
  logic [31:0] fetch_instr_i, fetch_pc_i, issue_instr_o, issue_pc_o;
  logic        issue_valid_o, issue_compressed_o, issue_illegal_o, issue_ctrl_flow_o;

  logic [31:0] lfsr;
  logic [31:0] pc_next;
  logic [31:0] exp_instr_q[$];
  logic [31:0] exp_pc_q[$];
  logic [2:0]  exp_flag_q[$];
  int          cycles, loads_cnt, exp_n;
  bit          hold_ack, started;
  string       test_name;

  id_stage_top #(.AddrWidth(32)) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic stop_fail(input string msg);
    $display("Error in %s: %s", test_name, msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_fail(input string what, input logic [31:0] e, input logic [31:0] a);
    $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, e, a);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic expect_entry(input logic [31:0] w, input logic comp, input logic ill,
                              input logic [31:0] pc);
    logic ctrl;
    ctrl = (w[6:0] == 7'h6f) || (w[6:0] == 7'h67) || (w[6:0] == 7'h63);
    exp_instr_q.push_back(w);
    exp_pc_q.push_back(pc);
    exp_flag_q.push_back({comp, ill, ctrl});
    exp_n++;
  endtask

  // Reference model of the expansion rules
  task automatic model(input logic [31:0] w, input logic [31:0] pc);
    logic [15:0] c;
    logic [4:0]  rd, rs2, r;
    logic [11:0] imm, off;
    int          n;
    c   = w[15:0];
    rd  = c[11:7];
    rs2 = c[6:2];
    imm = {{7{c[12]}}, c[6:2]};
    exp_n = 0;
    if (c[1:0] == 2'b11) expect_entry(w, 1'b0, 1'b0, pc);
    else if (c[1:0] == 2'b01 && c[15:13] == 3'b000)
      expect_entry({imm, rd, 3'b000, rd, 7'h13}, 1'b1, 1'b0, pc);
    else if (c[1:0] == 2'b01 && c[15:13] == 3'b010)
      expect_entry({imm, 5'd0, 3'b000, rd, 7'h13}, 1'b1, 1'b0, pc);
    else if (c[1:0] == 2'b10 && c[15:12] == 4'b1000 && rs2 != 0)
      expect_entry({7'd0, rs2, 5'd0, 3'b000, rd, 7'h33}, 1'b1, 1'b0, pc);
    else if (c[1:0] == 2'b10 && c[15:12] == 4'b1000 && rd != 0)
      expect_entry({12'd0, rd, 3'b000, 5'd0, 7'h67}, 1'b1, 1'b0, pc);
    else if (c[1:0] == 2'b10 && c[15:12] == 4'b1001 && rs2 != 0)
      expect_entry({7'd0, rs2, rd, 3'b000, rd, 7'h33}, 1'b1, 1'b0, pc);
    else if (c[15:8] == 8'hb8 && c[1:0] == 2'b10 && c[7:4] >= 4 && c[7:4] != 15) begin
      n = int'(c[7:4]) - 3;
      for (int i = 0; i < n; i++) begin
        r   = (i == 0) ? 5'd1 : (i == 1) ? 5'd8 : (i == 2) ? 5'd9 : 5'(15 + i);
        off = 12'(-4 * (i + 1));
        expect_entry({off[11:5], r, 5'd2, 3'b010, off[4:0], 7'h23}, 1'b1, 1'b0, pc);
      end
      off = 12'(-(((4 * n + 15) / 16) * 16 + 16 * int'(c[3:2])));
      expect_entry({off, 5'd2, 3'b000, 5'd2, 7'h13}, 1'b1, 1'b0, pc);
    end else expect_entry({16'h0000, c}, 1'b1, 1'b1, pc);
  endtask

  // Present one fetch entry and wait until it is consumed
  task automatic send(input logic [31:0] w);
    @(posedge clk_i);
    fetch_valid_i <= 1'b1;
    fetch_instr_i <= w;
    fetch_pc_i    <= pc_next;
    loads_cnt = 0;
    started   = 1'b1;
    model(w, pc_next);
    pc_next = pc_next + ((w[1:0] == 2'b11) ? 32'd4 : 32'd2);
    do @(negedge clk_i); while (!(fetch_valid_i && fetch_ready_o));
  endtask

  // Hold issue, present an entry, then flush it away
  task automatic flush_case(input logic [31:0] w);
    // Drain earlier entries so the held one belongs to this case
    @(posedge clk_i);
    fetch_valid_i <= 1'b0;
    do @(negedge clk_i); while (issue_valid_o);
    hold_ack = 1'b1;
    @(posedge clk_i);
    fetch_valid_i <= 1'b1;
    fetch_instr_i <= w;
    fetch_pc_i    <= pc_next;
    loads_cnt = 0;
    model(w, pc_next);
    repeat (3) @(posedge clk_i);
    flush_i       <= 1'b1;
    fetch_valid_i <= 1'b0;
    exp_instr_q.delete();
    exp_pc_q.delete();
    exp_flag_q.delete();
    exp_n     = 0;
    loads_cnt = 0;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    hold_ack = 1'b0;
  endtask

  always @(posedge clk_i) begin : ack_drive
    logic [31:0] v;
    rand_bits(2, v);
    issue_ack_i <= !hold_ack && (v[1:0] != 2'b00);
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= 4000) stop_fail("run did not finish within 4000 cycles");
  end

  // ------------------------------------------------------------------------
  // Checks, sampled on the falling edge where everything is stable
  // ------------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni) begin
      assert (started || !issue_valid_o) else stop_fail("issue valid before any fetch");
      if ((!issue_valid_o || issue_ack_i) && fetch_valid_i && !flush_i) loads_cnt++;
      assert (!(fetch_valid_i && fetch_ready_o) || loads_cnt == exp_n)
        else stop_fail("fetch ready raised before every micro-op was loaded");
      if (issue_valid_o && issue_ack_i) begin
        assert (exp_instr_q.size() != 0) else stop_fail("issue entry with nothing expected");
        assert (issue_instr_o == exp_instr_q[0])
          else check_fail("instr", exp_instr_q[0], issue_instr_o);
        assert (issue_pc_o == exp_pc_q[0]) else check_fail("pc", exp_pc_q[0], issue_pc_o);
        assert ({issue_compressed_o, issue_illegal_o, issue_ctrl_flow_o} == exp_flag_q[0])
          else check_fail("flags", 32'(exp_flag_q[0]),
                          {29'd0, issue_compressed_o, issue_illegal_o, issue_ctrl_flow_o});
        void'(exp_instr_q.pop_front());
        void'(exp_pc_q.pop_front());
        void'(exp_flag_q.pop_front());
      end
    end
  end

  initial begin
    logic [31:0] w, k;
    lfsr = 32'h478b_2935;
    pc_next = 32'h0000_1000;
    {rst_ni, flush_i, fetch_valid_i, issue_ack_i} = 4'b0000;
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    {hold_ack, started, cycles, loads_cnt, exp_n} = '0;
    test_name = "reset";
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (4) @(negedge clk_i);

    test_name = "pass32";
    for (int i = 0; i < 40; i++) begin
      rand_bits(32, w);
      w = w | 32'd3;
      // Some words get a branch, jal or jalr opcode
      case (i % 8)
        1: w[6:0] = 7'h63;
        4: w[6:0] = 7'h6f;
        6: w[6:0] = 7'h67;
        default: ;
      endcase
      send(w);
    end

    test_name = "rvc";
    repeat (60) begin
      rand_bits(3, k);
      rand_bits(32, w);
      case (k[2:0])
        3'd0: {w[15:13], w[1:0]} = 5'b000_01;
        3'd1: {w[15:13], w[1:0]} = 5'b010_01;
        3'd2: {w[15:12], w[1:0]} = 6'b1000_10;
        3'd3: {w[15:12], w[6:2], w[1:0]} = 11'b1000_00000_10;
        3'd4: {w[15:12], w[1:0]} = 6'b1001_10;
        default: w[1:0] = 2'b00;
      endcase
      send(w);
    end

    test_name = "push";
    for (int r = 0; r < 16; r++) begin
      for (int s = 0; s < 4; s++) begin
        rand_bits(32, w);
        w[15:0] = {8'hb8, 4'(r), 2'(s), 2'b10};
        send(w);
      end
    end

    test_name = "flush";
    flush_case(32'h0000_b8e6);
    send(32'h0041_0093);
    // A macro after the flush starts again from the first store
    send(32'h0000_b8a6);
    flush_case(32'h0020_8133);
    send(32'h0000_4505);

    test_name = "drain";
    @(posedge clk_i);
    fetch_valid_i <= 1'b0;
    while (exp_instr_q.size() != 0 || issue_valid_o) @(negedge clk_i);
    $display("** PASS **");
    $finish;
  end

endmodule

/* files.f */
id_pkg.sv
rvc_expander.sv
push_sequencer.sv
push_step_counter.sv
push_uop_gen.sv
issue_reg.sv
id_stage_top.sv
tb_id_stage.sv

/* Makefile */
# Verilator build for the decode stage and its testbench

VERILATOR ?= verilator
FLIST     ?= files.f
TB_TOP    ?= tb_id_stage
RTL_TOP   ?= id_stage_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= \*\* PASS \*\*

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -f $(FLIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TB_TOP) \
	  --Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BUILD_DIR)/V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
